// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module instruction_pipeline_tb \
		-Mdir obj_dir -f compile.f
	./obj_dir/Vinstruction_pipeline_tb | tee $(LOG)
	@if grep -q "tests failed" $(LOG) || ! grep -q "all tests passed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
hdl/pipeline_pkg.sv
hdl/ifetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/register_file.sv
hdl/control_registers.sv
hdl/instruction_pipeline.sv
tb/instruction_pipeline_properties.sv
tb/instruction_pipeline_tb.sv

// ==== hdl/control_registers.sv ====
/*
 * Control registers
 * Thread enable mask with halt handling and read-back of
 * the calling thread's id or the mask
 */

module control_registers #(
	parameter int THREADS = 4,
	localparam int TIDX_BITS = $clog2(THREADS)
) (
	input clk,
	input reset,
	input cr_write_en,
	input cr_halt_en,
	input [pipeline_pkg::CR_INDEX_BITS-1:0] cr_index,
	input [TIDX_BITS-1:0] cr_thread_idx,
	input [pipeline_pkg::WORD_BITS-1:0] cr_write_val,
	output logic [pipeline_pkg::WORD_BITS-1:0] cr_read_val,
	output logic [THREADS-1:0] cr_thread_enable
);

	always_ff @(posedge clk) begin
		if (reset)
			cr_thread_enable <= THREADS'(1);	// Thread 0 boots alone
		else if (cr_write_en && cr_index == pipeline_pkg::CR_THREAD_ENABLE)
			cr_thread_enable <= cr_write_val[THREADS-1:0];
		else if (cr_halt_en)
			cr_thread_enable[cr_thread_idx] <= 1'b0;	// Caller stops itself
	end

	always_comb begin
		case (cr_index)
			pipeline_pkg::CR_THREAD_ID: cr_read_val = pipeline_pkg::WORD_BITS'(cr_thread_idx);
			pipeline_pkg::CR_THREAD_ENABLE:
				cr_read_val = pipeline_pkg::WORD_BITS'(cr_thread_enable);
			default: cr_read_val = '0;	// Unmapped index
		endcase
	end
endmodule

// ==== hdl/decode_stage.sv ====
/*
 * Decode stage
 * Captures the returned instruction word, picks the register
 * numbers for its format and reads both operands
 */

module decode_stage #(
	parameter int THREADS = 4,
	localparam int TIDX_BITS = $clog2(THREADS)
) (
	input clk,
	input reset,

	// From fetch and instruction memory
	input ift_instruction_valid,
	input [TIDX_BITS-1:0] ift_thread_idx,
	input [pipeline_pkg::WORD_BITS-1:0] ift_pc,
	input [pipeline_pkg::WORD_BITS-1:0] icache_data,

	// Register file read port
	output logic [TIDX_BITS-1:0] rf_read_thread_idx,
	output logic [pipeline_pkg::REG_IDX_BITS-1:0] rf_read_idx1,
	output logic [pipeline_pkg::REG_IDX_BITS-1:0] rf_read_idx2,
	input [pipeline_pkg::WORD_BITS-1:0] rf_read_val1,
	input [pipeline_pkg::WORD_BITS-1:0] rf_read_val2,

	// To execute
	output logic id_instruction_valid,
	output logic [TIDX_BITS-1:0] id_thread_idx,
	output logic [pipeline_pkg::WORD_BITS-1:0] id_pc,
	output pipeline_pkg::instruction_t id_instruction,
	output logic [pipeline_pkg::WORD_BITS-1:0] id_operand1,
	output logic [pipeline_pkg::WORD_BITS-1:0] id_operand2
);

	logic ifd_instruction_valid;	// Fetch info, one cycle after request
	logic [TIDX_BITS-1:0] ifd_thread_idx;
	logic [pipeline_pkg::WORD_BITS-1:0] ifd_pc;
	pipeline_pkg::instruction_t fetched;
	logic is_reg_format;

	assign fetched = icache_data;	// Memory answers this cycle
	assign is_reg_format = fetched.r.opcode <= pipeline_pkg::OP_SLT;	// Opcodes 0 to 5

	assign rf_read_thread_idx = ifd_thread_idx;
	assign rf_read_idx1 = fetched.r.rs1;	// Same bits in both views
	assign rf_read_idx2 = is_reg_format ? fetched.r.rs2 : fetched.i.rd;

	always_ff @(posedge clk) begin
		if (reset) begin
			ifd_instruction_valid <= 1'b0;
			id_instruction_valid <= 1'b0;
		end else begin
			ifd_instruction_valid <= ift_instruction_valid;
			id_instruction_valid <= ifd_instruction_valid;
		end
	end

	always_ff @(posedge clk) begin
		ifd_thread_idx <= ift_thread_idx;
		ifd_pc <= ift_pc;
		id_thread_idx <= ifd_thread_idx;
		id_pc <= ifd_pc;
		id_instruction <= fetched;
		id_operand1 <= rf_read_val1;	// rs1 value
		id_operand2 <= rf_read_val2;	// rs2 or rd value
	end
endmodule

// ==== hdl/execute_stage.sv ====
/*
 * Execute stage
 * ALU and immediate arithmetic, BEQZ resolution, data memory
 * requests and control register access, then registers the
 * writeback fields for the register file
 */

module execute_stage #(
	parameter int THREADS = 4,
	localparam int TIDX_BITS = $clog2(THREADS)
) (
	input clk,
	input reset,

	// From decode
	input id_instruction_valid,
	input [TIDX_BITS-1:0] id_thread_idx,
	input [pipeline_pkg::WORD_BITS-1:0] id_pc,
	input pipeline_pkg::instruction_t id_instruction,
	input [pipeline_pkg::WORD_BITS-1:0] id_operand1,
	input [pipeline_pkg::WORD_BITS-1:0] id_operand2,

	// Data memory
	output logic [pipeline_pkg::WORD_BITS-1:0] dcache_request_addr,
	output logic dcache_read_en,
	output logic dcache_write_en,
	output logic [pipeline_pkg::WORD_BITS-1:0] dcache_write_data,

	// To fetch
	output logic branch_en,
	output logic [TIDX_BITS-1:0] branch_thread_idx,
	output logic [pipeline_pkg::WORD_BITS-1:0] branch_pc,

	// Control registers
	output logic cr_write_en,
	output logic cr_halt_en,
	output logic [pipeline_pkg::CR_INDEX_BITS-1:0] cr_index,
	output logic [TIDX_BITS-1:0] cr_thread_idx,
	output logic [pipeline_pkg::WORD_BITS-1:0] cr_write_val,
	input [pipeline_pkg::WORD_BITS-1:0] cr_read_val,

	// To register file
	output logic ex_writeback_en,
	output logic [TIDX_BITS-1:0] ex_thread_idx,
	output logic [pipeline_pkg::REG_IDX_BITS-1:0] ex_rd,
	output logic [pipeline_pkg::WORD_BITS-1:0] ex_result,
	output logic ex_is_load
);

	logic [3:0] opcode;
	logic [pipeline_pkg::WORD_BITS-1:0] imm_ext;
	logic [pipeline_pkg::WORD_BITS-1:0] result;
	logic writes_rd;

	assign opcode = id_instruction.r.opcode;
	assign imm_ext = {{(pipeline_pkg::WORD_BITS - 20){id_instruction.i.imm[19]}},
		id_instruction.i.imm};	// Sign extend

	always_comb begin
		result = '0;
		case (opcode)
			pipeline_pkg::OP_ADD: result = id_operand1 + id_operand2;
			pipeline_pkg::OP_SUB: result = id_operand1 - id_operand2;
			pipeline_pkg::OP_AND: result = id_operand1 & id_operand2;
			pipeline_pkg::OP_OR: result = id_operand1 | id_operand2;
			pipeline_pkg::OP_XOR: result = id_operand1 ^ id_operand2;
			pipeline_pkg::OP_SLT: result[0] = $signed(id_operand1) < $signed(id_operand2);
			pipeline_pkg::OP_ADDI: result = id_operand1 + imm_ext;
			pipeline_pkg::OP_CRR: result = cr_read_val;
			default: result = '0;	// Loads take memory data later
		endcase
	end

	// ALU ops and ADDI are codes 0 to 6
	assign writes_rd = opcode <= pipeline_pkg::OP_ADDI || opcode == pipeline_pkg::OP_LW
		|| opcode == pipeline_pkg::OP_CRR;

	// Memory request
	assign dcache_request_addr = id_operand1 + imm_ext;
	assign dcache_read_en = id_instruction_valid && opcode == pipeline_pkg::OP_LW;
	assign dcache_write_en = id_instruction_valid && opcode == pipeline_pkg::OP_SW;
	assign dcache_write_data = id_operand2;	// rd value

	// BEQZ tests rd
	assign branch_en = id_instruction_valid && opcode == pipeline_pkg::OP_BEQZ
		&& id_operand2 == '0;
	assign branch_thread_idx = id_thread_idx;
	assign branch_pc = id_pc + pipeline_pkg::WORD_BITS'(1) + imm_ext;

	// Control register access
	assign cr_write_en = id_instruction_valid && opcode == pipeline_pkg::OP_CRW;
	assign cr_halt_en = id_instruction_valid && opcode == pipeline_pkg::OP_HALT;
	assign cr_index = id_instruction.i.imm[pipeline_pkg::CR_INDEX_BITS-1:0];
	assign cr_thread_idx = id_thread_idx;
	assign cr_write_val = id_operand2;

	always_ff @(posedge clk) begin
		if (reset)
			ex_writeback_en <= 1'b0;
		else
			ex_writeback_en <= id_instruction_valid && writes_rd && id_instruction.i.rd != '0;
	end

	always_ff @(posedge clk) begin
		ex_thread_idx <= id_thread_idx;
		ex_rd <= id_instruction.i.rd;
		ex_result <= result;
		ex_is_load <= opcode == pipeline_pkg::OP_LW;	// Data arrives next cycle
	end
endmodule

// ==== hdl/ifetch_stage.sv ====
/*
 * Instruction fetch stage
 * Rotates a slot counter over the hardware threads and issues
 * the enabled thread's PC to instruction memory each cycle
 */

module ifetch_stage #(
	parameter int THREADS = 4,
	localparam int TIDX_BITS = $clog2(THREADS)
) (
	input clk,
	input reset,

	// From control registers
	input [THREADS-1:0] cr_thread_enable,

	// From execute
	input branch_en,
	input [TIDX_BITS-1:0] branch_thread_idx,
	input [pipeline_pkg::WORD_BITS-1:0] branch_pc,

	// To instruction memory and decode
	output logic [pipeline_pkg::WORD_BITS-1:0] icache_request_addr,
	output logic ift_instruction_valid,
	output logic [TIDX_BITS-1:0] ift_thread_idx,
	output logic [pipeline_pkg::WORD_BITS-1:0] ift_pc
);

	logic [TIDX_BITS-1:0] slot;	// Thread owning this cycle
	logic [pipeline_pkg::WORD_BITS-1:0] pc [THREADS];	// Next fetch address per thread

	assign ift_thread_idx = slot;
	assign ift_pc = pc[slot];
	assign icache_request_addr = pc[slot];	// Word address
	assign ift_instruction_valid = cr_thread_enable[slot];	// Disabled slot stays idle

	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= '0;
			for (int t = 0; t < THREADS; t++)
				pc[t] <= pipeline_pkg::WORD_BITS'(t * 256);	// 256-word region per thread
		end else begin
			slot <= slot + 1'b1;	// Wraps since THREADS is a power of two
			if (ift_instruction_valid)
				pc[slot] <= pc[slot] + 1'b1;

			// Branching thread is two slots behind the fetch slot
			// so both updates land on different entries
			if (branch_en)
				pc[branch_thread_idx] <= branch_pc;
		end
	end
endmodule

// ==== hdl/instruction_pipeline.sv ====
/*
 * Barrel-threaded scalar core top level
 * Fetch, decode and execute stages with register file and
 * control registers; halts once every thread is disabled
 */

module instruction_pipeline #(
	parameter int THREADS = 4,
	localparam int TIDX_BITS = $clog2(THREADS)
) (
	input clk,
	input reset,
	output logic processor_halt,

	// Instruction memory
	output logic [pipeline_pkg::WORD_BITS-1:0] icache_request_addr,
	input [pipeline_pkg::WORD_BITS-1:0] icache_data,

	// Data memory
	output logic [pipeline_pkg::WORD_BITS-1:0] dcache_request_addr,
	output logic dcache_read_en,
	input [pipeline_pkg::WORD_BITS-1:0] dcache_read_data,
	output logic dcache_write_en,
	output logic [pipeline_pkg::WORD_BITS-1:0] dcache_write_data
);

	logic [THREADS-1:0] cr_thread_enable;	// Control registers to fetch
	logic branch_en;	// Execute to fetch
	logic [TIDX_BITS-1:0] branch_thread_idx;
	logic [pipeline_pkg::WORD_BITS-1:0] branch_pc;
	logic ift_instruction_valid;	// Fetch to decode
	logic [TIDX_BITS-1:0] ift_thread_idx;
	logic [pipeline_pkg::WORD_BITS-1:0] ift_pc;
	logic [TIDX_BITS-1:0] rf_read_thread_idx;	// Decode register reads
	logic [pipeline_pkg::REG_IDX_BITS-1:0] rf_read_idx1;
	logic [pipeline_pkg::REG_IDX_BITS-1:0] rf_read_idx2;
	logic [pipeline_pkg::WORD_BITS-1:0] rf_read_val1;
	logic [pipeline_pkg::WORD_BITS-1:0] rf_read_val2;
	logic id_instruction_valid;	// Decode to execute
	logic [TIDX_BITS-1:0] id_thread_idx;
	logic [pipeline_pkg::WORD_BITS-1:0] id_pc;
	pipeline_pkg::instruction_t id_instruction;
	logic [pipeline_pkg::WORD_BITS-1:0] id_operand1;
	logic [pipeline_pkg::WORD_BITS-1:0] id_operand2;
	logic cr_write_en;	// Execute to control registers
	logic cr_halt_en;
	logic [pipeline_pkg::CR_INDEX_BITS-1:0] cr_index;
	logic [TIDX_BITS-1:0] cr_thread_idx;
	logic [pipeline_pkg::WORD_BITS-1:0] cr_write_val;
	logic [pipeline_pkg::WORD_BITS-1:0] cr_read_val;
	logic ex_writeback_en;	// Execute to register file
	logic [TIDX_BITS-1:0] ex_thread_idx;
	logic [pipeline_pkg::REG_IDX_BITS-1:0] ex_rd;
	logic [pipeline_pkg::WORD_BITS-1:0] ex_result;
	logic ex_is_load;

	ifetch_stage #(.THREADS(THREADS)) ifetch_stage(.*);
	decode_stage #(.THREADS(THREADS)) decode_stage(.*);
	execute_stage #(.THREADS(THREADS)) execute_stage(.*);
	register_file #(.THREADS(THREADS)) register_file(.*);
	control_registers #(.THREADS(THREADS)) control_registers(.*);

	assign processor_halt = !(|cr_thread_enable);	// No thread left to run
endmodule

// ==== hdl/pipeline_pkg.sv ====
/*
 * Pipeline package for the barrel-threaded scalar core
 * Instruction word layout in its two formats, opcode values
 * and control register indexes shared by all stages
 */

package pipeline_pkg;
	localparam int WORD_BITS = 32;	// Data and word address width
	localparam int REG_IDX_BITS = 4;	// 16 registers per thread
	localparam int CR_INDEX_BITS = 4;	// Low bits of imm pick the control register

	// One word seen two ways, selected by opcode
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [REG_IDX_BITS-1:0] rd;
			logic [REG_IDX_BITS-1:0] rs1;
			logic [REG_IDX_BITS-1:0] rs2;
			logic [15:0] unused;	// Ignored by decode
		} r;	// Register-register ALU format
		struct packed {
			logic [3:0] opcode;
			logic [REG_IDX_BITS-1:0] rd;	// Also store data, branch test, CR write source
			logic [REG_IDX_BITS-1:0] rs1;	// Base for ADDI and memory address
			logic signed [19:0] imm;
		} i;	// Immediate format
	} instruction_t;

	// Register format
	localparam logic [3:0] OP_ADD = 4'd0;
	localparam logic [3:0] OP_SUB = 4'd1;
	localparam logic [3:0] OP_AND = 4'd2;
	localparam logic [3:0] OP_OR = 4'd3;
	localparam logic [3:0] OP_XOR = 4'd4;
	localparam logic [3:0] OP_SLT = 4'd5;	// Signed less-than

	// Immediate format
	localparam logic [3:0] OP_ADDI = 4'd6;
	localparam logic [3:0] OP_LW = 4'd7;	// rd = mem[rs1 + imm]
	localparam logic [3:0] OP_SW = 4'd8;	// mem[rs1 + imm] = rd
	localparam logic [3:0] OP_BEQZ = 4'd9;	// pc = pc + 1 + imm if rd is zero
	localparam logic [3:0] OP_CRR = 4'd10;	// rd = cr[imm]
	localparam logic [3:0] OP_CRW = 4'd11;	// cr[imm] = rd
	localparam logic [3:0] OP_HALT = 4'd12;	// Clears own enable bit
	// Codes 13 to 15 fall through as no-ops

	// Control register indexes
	localparam logic [CR_INDEX_BITS-1:0] CR_THREAD_ID = 4'd0;	// Read only
	localparam logic [CR_INDEX_BITS-1:0] CR_THREAD_ENABLE = 4'd1;	// One bit per thread
endpackage

// ==== hdl/register_file.sv ====
/*
 * Register file
 * Sixteen words per thread with two combinational read ports
 * and one write port that retires ALU or load results
 */

module register_file #(
	parameter int THREADS = 4,
	localparam int TIDX_BITS = $clog2(THREADS)
) (
	input clk,
	input reset,

	// Read port from decode
	input [TIDX_BITS-1:0] rf_read_thread_idx,
	input [pipeline_pkg::REG_IDX_BITS-1:0] rf_read_idx1,
	input [pipeline_pkg::REG_IDX_BITS-1:0] rf_read_idx2,
	output logic [pipeline_pkg::WORD_BITS-1:0] rf_read_val1,
	output logic [pipeline_pkg::WORD_BITS-1:0] rf_read_val2,

	// Write port from execute and data memory
	input ex_writeback_en,
	input [TIDX_BITS-1:0] ex_thread_idx,
	input [pipeline_pkg::REG_IDX_BITS-1:0] ex_rd,
	input [pipeline_pkg::WORD_BITS-1:0] ex_result,
	input ex_is_load,
	input [pipeline_pkg::WORD_BITS-1:0] dcache_read_data
);

	localparam int REGS = 2 ** pipeline_pkg::REG_IDX_BITS;

	logic [pipeline_pkg::WORD_BITS-1:0] registers [THREADS][REGS];
	logic [pipeline_pkg::WORD_BITS-1:0] writeback_val;

	// r0 is hardwired to zero
	assign rf_read_val1 = rf_read_idx1 == '0 ? '0 : registers[rf_read_thread_idx][rf_read_idx1];
	assign rf_read_val2 = rf_read_idx2 == '0 ? '0 : registers[rf_read_thread_idx][rf_read_idx2];

	assign writeback_val = ex_is_load ? dcache_read_data : ex_result;	// Load data wins

	always_ff @(posedge clk) begin
		if (ex_writeback_en && !reset)	// No retire while in reset
			registers[ex_thread_idx][ex_rd] <= writeback_val;
	end
endmodule

// ==== tb/instruction_pipeline_properties.sv ====
/*
 * Concurrent checks bound into the core top level
 * Data memory strobes are exclusive and quiet in reset, and
 * no data request is made once the core has stayed halted
 */

module instruction_pipeline_properties (
	input clk,
	input reset,
	input processor_halt,
	input dcache_read_en,
	input dcache_write_en
);
	timeunit 1ns;
	timeprecision 100ps;

	// Load and store never share a cycle
	strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(dcache_read_en && dcache_write_en))
		else $error("data memory read and write strobes high together");

	// Skip the first reset cycle while pipeline state settles
	strobes_quiet_in_reset: assert property (@(posedge clk)
		reset && $past(reset) |-> !dcache_read_en && !dcache_write_en)
		else $error("data memory strobe high during reset");

	// Two in-flight instructions may still drain after the mask clears
	no_request_when_halted: assert property (@(posedge clk) disable iff (reset)
		processor_halt && $past(processor_halt) && $past(processor_halt, 2)
		|-> !dcache_read_en && !dcache_write_en)
		else $error("memory request after processor_halt held for three cycles");
endmodule

bind instruction_pipeline instruction_pipeline_properties properties_i (
	.clk(clk),
	.reset(reset),
	.processor_halt(processor_halt),
	.dcache_read_en(dcache_read_en),
	.dcache_write_en(dcache_write_en)
);

// ==== tb/instruction_pipeline_tb.sv ====
/*
 * Testbench for the barrel-threaded core
 * Random per-thread programs run against an instruction-set model;
 * fetch addresses, data memory traffic, halt and memory are compared
 */

module instruction_pipeline_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int THREADS = 4;
	localparam int ROUNDS = 8;
	localparam int BODY_LEN = 48;	// Generated words per region
	localparam int REGION = 256;	// Words per thread region
	localparam int CLK_PERIOD = 8;
	localparam int ROUND_CYCLES = THREADS * 64 * 8;	// Halt must arrive within this
	localparam int WATCHDOG_CYCLES = ROUNDS * ROUND_CYCLES * 2;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic processor_halt;
	logic [31:0] icache_request_addr;
	logic [31:0] icache_data = '0;
	logic [31:0] dcache_request_addr;
	logic dcache_read_en;
	logic [31:0] dcache_read_data = '0;
	logic dcache_write_en;
	logic [31:0] dcache_write_data;

	logic [31:0] imem [THREADS*REGION];	// Program for all threads
	logic [31:0] dmem [256];	// Memory seen by the DUT
	logic [31:0] dmem_init [256];	// Copied into dmem during reset
	logic [31:0] model_dmem [256];
	logic [31:0] model_regs [THREADS][16];
	logic [31:0] model_pc [THREADS];
	logic [THREADS-1:0] arch_mask;	// Mask after the last fetched instruction
	logic [THREADS-1:0] mask_d1;
	logic [THREADS-1:0] mask_d2;
	logic [THREADS-1:0] mask_d3;	// Mask seen by this cycle's fetch
	logic [64:0] expected_mem [$];	// Store flag, address, data
	logic [31:0] lfsr = 32'hf3013819;
	int mismatch_count = 0;
	int other_failures = 0;

	instruction_pipeline #(.THREADS(THREADS)) dut_i (
		.clk,
		.reset,
		.processor_halt,
		.icache_request_addr,
		.icache_data,
		.dcache_request_addr,
		.dcache_read_en,
		.dcache_read_data,
		.dcache_write_en,
		.dcache_write_data
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Both memories answer one cycle after the request
	always @(posedge clk) begin
		icache_data <= imem[icache_request_addr[9:0]];
		if (reset) begin
			for (int i = 0; i < 256; i++)
				dmem[i] <= dmem_init[i];
		end else begin
			if (dcache_write_en)
				dmem[dcache_request_addr[7:0]] <= dcache_write_data;
			if (dcache_read_en)
				dcache_read_data <= dmem[dcache_request_addr[7:0]];
		end
	end

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] next_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic logic [31:0] random_instruction();
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] rs1;
		logic [3:0] rs2;
		logic [19:0] imm;
		op = 4'(next_bits(4));	// 13 to 15 stay as no-ops
		rd = 4'(next_bits(4));
		rs1 = 4'(next_bits(4));
		rs2 = 4'(next_bits(4));
		imm = 20'(next_bits(20));
		if (op == pipeline_pkg::OP_HALT && next_bits(2) != 0)
			op = pipeline_pkg::OP_ADDI;	// Keep halts rare
		case (op)
			pipeline_pkg::OP_BEQZ: begin
				imm = 20'(next_bits(4));	// Forward only
				if (next_bits(1) != 0)
					rd = 4'd0;	// Taken for sure
			end
			pipeline_pkg::OP_CRR, pipeline_pkg::OP_CRW: imm = 20'(next_bits(2));
			default: ;
		endcase
		if (op <= pipeline_pkg::OP_SLT)
			return {op, rd, rs1, rs2, 16'(next_bits(16))};	// Junk in unused bits
		return {op, rd, rs1, imm};
	endfunction

	task automatic generate_program();
		int base;
		int pos;
		int first_reg;
		for (int t = 0; t < THREADS; t++) begin
			base = t * REGION;
			for (int i = 0; i < REGION; i++)
				imem[base + i] = {pipeline_pkg::OP_HALT, 28'd0};
			pos = 0;
			first_reg = 1;
			if (t == 0) begin	// Boot thread wakes all others
				imem[base] = {pipeline_pkg::OP_ADDI, 4'd1, 4'd0, 20'hfffff};
				imem[base + 1] = {pipeline_pkg::OP_CRW, 4'd1, 4'd0, 16'd0,
					pipeline_pkg::CR_THREAD_ENABLE};
				pos = 2;
				first_reg = 2;
			end
			for (int r = first_reg; r < 16; r++) begin	// Defined value in each register
				imem[base + pos] = {pipeline_pkg::OP_ADDI, 4'(r), 4'd0, 20'(next_bits(20))};
				pos++;
			end
			while (pos < BODY_LEN) begin
				imem[base + pos] = random_instruction();
				pos++;
			end
		end
	endtask

	task automatic report_mismatch(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERR %s expected %h actual %h at %0t", test_name, expected, actual, $time);
		mismatch_count++;
	endtask

	// One slot of the instruction-set model, checked against fetch and halt
	task automatic model_cycle(input int slot);
		logic [31:0] word;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] d;
		logic [31:0] imm;
		logic [31:0] addr;
		logic [31:0] value;
		logic [3:0] op;
		logic [3:0] rd;
		logic writes;
		if (processor_halt !== (mask_d3 == '0))
			report_mismatch("halt", 32'(mask_d3 == '0), 32'(processor_halt));
		if (mask_d3[slot]) begin
			if (icache_request_addr !== model_pc[slot])
				report_mismatch("fetch", model_pc[slot], icache_request_addr);
			word = imem[model_pc[slot][9:0]];
			model_pc[slot] = model_pc[slot] + 1;
			op = word[31:28];
			rd = word[27:24];
			a = model_regs[slot][word[23:20]];
			b = model_regs[slot][word[19:16]];	// Only meaningful in register format
			d = model_regs[slot][rd];
			imm = {{12{word[19]}}, word[19:0]};
			addr = a + imm;
			value = '0;
			writes = 1'b1;
			case (op)
				pipeline_pkg::OP_ADD: value = a + b;
				pipeline_pkg::OP_SUB: value = a - b;
				pipeline_pkg::OP_AND: value = a & b;
				pipeline_pkg::OP_OR: value = a | b;
				pipeline_pkg::OP_XOR: value = a ^ b;
				pipeline_pkg::OP_SLT: value = {31'd0, $signed(a) < $signed(b)};
				pipeline_pkg::OP_ADDI: value = addr;
				pipeline_pkg::OP_LW: begin
					expected_mem.push_back({1'b0, addr, 32'd0});
					value = model_dmem[addr[7:0]];
				end
				pipeline_pkg::OP_SW: begin
					expected_mem.push_back({1'b1, addr, d});
					model_dmem[addr[7:0]] = d;
					writes = 1'b0;
				end
				pipeline_pkg::OP_BEQZ: begin
					if (d == '0)
						model_pc[slot] = model_pc[slot] + imm;	// pc + 1 + imm
					writes = 1'b0;
				end
				pipeline_pkg::OP_CRR: begin
					if (word[3:0] == pipeline_pkg::CR_THREAD_ID)
						value = 32'(slot);
					else if (word[3:0] == pipeline_pkg::CR_THREAD_ENABLE)
						value = 32'(arch_mask);
				end
				pipeline_pkg::OP_CRW: begin
					if (word[3:0] == pipeline_pkg::CR_THREAD_ENABLE)
						arch_mask = d[THREADS-1:0];
					writes = 1'b0;
				end
				pipeline_pkg::OP_HALT: begin
					arch_mask[slot] = 1'b0;
					writes = 1'b0;
				end
				default: writes = 1'b0;	// No-op codes
			endcase
			if (writes && rd != 4'd0)
				model_regs[slot][rd] = value;
		end
		mask_d3 = mask_d2;	// Enable change reaches fetch three slots later
		mask_d2 = mask_d1;
		mask_d1 = arch_mask;
	endtask

	task automatic check_data_request();
		logic [64:0] exp;
		if (dcache_read_en || dcache_write_en) begin
			if (expected_mem.size() == 0) begin
				$display("data memory request at %0t that the model never made", $time);
				other_failures++;
			end else begin
				exp = expected_mem.pop_front();
				if (dcache_write_en !== exp[64]) begin
					report_mismatch("access kind", 32'(exp[64]), 32'(dcache_write_en));
				end else if (dcache_write_en) begin
					if (dcache_request_addr !== exp[63:32])
						report_mismatch("store address", exp[63:32], dcache_request_addr);
					if (dcache_write_data !== exp[31:0])
						report_mismatch("store data", exp[31:0], dcache_write_data);
				end else if (dcache_request_addr !== exp[63:32]) begin
					report_mismatch("load address", exp[63:32], dcache_request_addr);
				end
			end
		end
	endtask

	initial begin
		int cycle;
		bit done;
		for (int t = 0; t < THREADS; t++)
			for (int r = 0; r < 16; r++)
				model_regs[t][r] = '0;	// DUT registers persist across rounds, so these do too
		for (int round = 0; round < ROUNDS; round++) begin
			generate_program();
			for (int i = 0; i < 256; i++) begin
				dmem_init[i] = next_bits(32);
				model_dmem[i] = dmem_init[i];
			end
			for (int t = 0; t < THREADS; t++)
				model_pc[t] = t * REGION;
			arch_mask = THREADS'(1);	// Thread 0 alone after reset
			mask_d1 = THREADS'(1);
			mask_d2 = THREADS'(1);
			mask_d3 = THREADS'(1);
			expected_mem.delete();
			@(posedge clk);
			reset <= 1'b1;
			repeat (16) @(posedge clk);
			reset <= 1'b0;
			cycle = 0;
			done = 1'b0;
			while (!done) begin
				@(negedge clk);
				if (cycle == 0) begin
					if (dcache_read_en !== 1'b0 || dcache_write_en !== 1'b0) begin
						$display("data memory strobe active right after reset in round %0d", round);
						other_failures++;
					end
					if (icache_request_addr !== 32'd0)
						report_mismatch("reset fetch", 32'd0, icache_request_addr);
				end
				model_cycle(cycle % THREADS);
				check_data_request();
				cycle++;
				if (mask_d1 == '0 && mask_d2 == '0 && mask_d3 == '0) begin
					done = 1'b1;	// Nothing left that could re-enable a thread
				end else if (cycle >= ROUND_CYCLES) begin
					$display("processor_halt never arrived in round %0d", round);
					$display("tests failed");
					$finish;
				end
			end
			repeat (4) begin	// Let in-flight stores and loads retire
				@(negedge clk);
				model_cycle(cycle % THREADS);
				check_data_request();
				cycle++;
			end
			if (expected_mem.size() != 0) begin
				$display("%0d model memory accesses never reached the DUT in round %0d",
					expected_mem.size(), round);
				other_failures++;
			end
			for (int i = 0; i < 256; i++)
				if (dmem[i] !== model_dmem[i])
					report_mismatch("final memory", model_dmem[i], dmem[i]);
		end
		$display("mismatches %0d, other failures %0d", mismatch_count, other_failures);
		if (mismatch_count == 0 && other_failures == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles before all rounds ended", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end
endmodule
